//--- riscv_pipe_params.svh
`ifndef RISCV_PIPE_PARAMS_SVH
`define RISCV_PIPE_PARAMS_SVH

// Data path width
`define XLEN 32

// Register index width
`define REG_ADDR_W 5

// First fetch address
`define RESET_PC 32'h0000_0000

`endif

//--- riscv_pkg.sv
package riscv_pkg;

  // RV32I major opcodes of the supported subset
  typedef enum logic [6:0] {
    OpReg  = 7'b0110011,
    OpImm  = 7'b0010011,
    Lui    = 7'b0110111,
    Load   = 7'b0000011,
    Store  = 7'b0100011,
    Branch = 7'b1100011,
    Jal    = 7'b1101111
  } opcode_t;

  typedef enum logic [2:0] {
    AluAdd,
    AluSub,
    AluAnd,
    AluOr,
    AluXor,
    AluSlt,
    AluPassB
  } alu_op_t;

  // Operand source for the ID and EX forwarding muxes
  typedef enum logic [1:0] {
    NoForwarding,
    ForwardFromMem,
    ForwardFromWb
  } forwarding_t;

  // Writeback data source
  typedef enum logic [1:0] {
    WrAluY,
    WrReadData,
    WrPcPlus4
  } wr_reg_t;

  typedef enum logic [1:0] {
    BranchNone,
    BranchEq,
    BranchNe,
    BranchJal
  } branch_t;

endpackage

//--- pipe_ifs.sv
`include "riscv_pipe_params.svh"

interface ctrl_if;
  riscv_pkg::opcode_t opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  riscv_pkg::alu_op_t alu_op;
  logic alub_src;
  riscv_pkg::wr_reg_t wr_reg_src;
  logic wr_reg_en;
  logic mem_rd_en;
  logic mem_wr_en;
  riscv_pkg::branch_t branch_type;

  modport decoder (
    input  opcode, funct3, funct7,
    output alu_op, alub_src, wr_reg_src, wr_reg_en, mem_rd_en, mem_wr_en, branch_type
  );

  modport datapath (
    output opcode, funct3, funct7,
    input  alu_op, alub_src, wr_reg_src, wr_reg_en, mem_rd_en, mem_wr_en, branch_type
  );
endinterface

// Clock only samples the hazard unit checks
interface hazard_if (input logic clock);
  logic [`REG_ADDR_W-1:0] rs1_id;
  logic [`REG_ADDR_W-1:0] rs2_id;
  logic [`REG_ADDR_W-1:0] rs1_ex;
  logic [`REG_ADDR_W-1:0] rs2_ex;
  logic [`REG_ADDR_W-1:0] rd_ex;
  logic [`REG_ADDR_W-1:0] rd_mem;
  logic [`REG_ADDR_W-1:0] rd_wb;
  logic reg_we_ex;
  logic reg_we_mem;
  logic reg_we_wb;
  logic mem_rd_en_ex;
  logic mem_rd_en_mem;
  logic branch_id;
  logic branch_taken;
  riscv_pkg::forwarding_t forward_rs1_id;
  riscv_pkg::forwarding_t forward_rs2_id;
  riscv_pkg::forwarding_t forward_rs1_ex;
  riscv_pkg::forwarding_t forward_rs2_ex;
  logic stall;
  logic flush_id;

  modport unit (
    input  clock, rs1_id, rs2_id, rs1_ex, rs2_ex, rd_ex, rd_mem, rd_wb,
    input  reg_we_ex, reg_we_mem, reg_we_wb, mem_rd_en_ex, mem_rd_en_mem,
    input  branch_id, branch_taken,
    output forward_rs1_id, forward_rs2_id, forward_rs1_ex, forward_rs2_ex, stall, flush_id
  );

  modport datapath (
    output rs1_id, rs2_id, rs1_ex, rs2_ex, rd_ex, rd_mem, rd_wb,
    output reg_we_ex, reg_we_mem, reg_we_wb, mem_rd_en_ex, mem_rd_en_mem,
    output branch_id, branch_taken,
    input  forward_rs1_id, forward_rs2_id, forward_rs1_ex, forward_rs2_ex, stall, flush_id
  );
endinterface

//--- register_file.sv
`include "riscv_pipe_params.svh"

module register_file (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   write_enable,
  input  logic [`REG_ADDR_W-1:0] write_address,
  input  logic [`XLEN-1:0]       write_data,
  input  logic [`REG_ADDR_W-1:0] read_address1,
  input  logic [`REG_ADDR_W-1:0] read_address2,
  output logic [`XLEN-1:0]       read_data1,
  output logic [`XLEN-1:0]       read_data2
);
  logic [`XLEN-1:0] registers [2**`REG_ADDR_W];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 2**`REG_ADDR_W; i++) begin
        registers[i] <= '0;
      end
    end else if (write_enable && write_address != '0) begin
      registers[write_address] <= write_data;
    end
  end

  // No internal bypass, WB results reach ID through the forwarding mux
  assign read_data1 = registers[read_address1];
  assign read_data2 = registers[read_address2];

  x0_stays_zero: assert property (@(posedge clock) disable iff (reset)
    write_enable && write_address == '0 |=> registers[0] == '0);

endmodule

//--- alu.sv
`include "riscv_pipe_params.svh"

module alu (
  input  logic [`XLEN-1:0]  a,
  input  logic [`XLEN-1:0]  b,
  input  riscv_pkg::alu_op_t alu_op,
  output logic [`XLEN-1:0]  y
);
  logic less_than;

  assign less_than = $signed(a) < $signed(b);

  always_comb begin
    case (alu_op)
      riscv_pkg::AluAdd: begin
        y = a + b;
      end
      riscv_pkg::AluSub: begin
        y = a - b;
      end
      riscv_pkg::AluAnd: begin
        y = a & b;
      end
      riscv_pkg::AluOr: begin
        y = a | b;
      end
      riscv_pkg::AluXor: begin
        y = a ^ b;
      end
      riscv_pkg::AluSlt: begin
        y = {{(`XLEN-1){1'b0}}, less_than};
      end
      riscv_pkg::AluPassB: begin
        y = b;
      end
      default: begin
        y = '0;
      end
    endcase
  end

endmodule

//--- control_unit.sv
module control_unit (
  ctrl_if.decoder ctrl
);

  always_comb begin
    // Anything not matched below stays a no-op
    ctrl.alu_op = riscv_pkg::AluAdd;
    ctrl.alub_src = 1'b0;
    ctrl.wr_reg_src = riscv_pkg::WrAluY;
    ctrl.wr_reg_en = 1'b0;
    ctrl.mem_rd_en = 1'b0;
    ctrl.mem_wr_en = 1'b0;
    ctrl.branch_type = riscv_pkg::BranchNone;
    case (ctrl.opcode)
      riscv_pkg::OpReg: begin
        // SUB is the only funct7 variant in the subset
        if (ctrl.funct7 == 7'b0000000 ||
            (ctrl.funct7 == 7'b0100000 && ctrl.funct3 == 3'b000)) begin
          ctrl.wr_reg_en = 1'b1;
          case (ctrl.funct3)
            3'b000: ctrl.alu_op = ctrl.funct7[5] ? riscv_pkg::AluSub : riscv_pkg::AluAdd;
            3'b010: ctrl.alu_op = riscv_pkg::AluSlt;
            3'b100: ctrl.alu_op = riscv_pkg::AluXor;
            3'b110: ctrl.alu_op = riscv_pkg::AluOr;
            3'b111: ctrl.alu_op = riscv_pkg::AluAnd;
            default: ctrl.wr_reg_en = 1'b0;
          endcase
        end
      end
      riscv_pkg::OpImm: begin
        if (ctrl.funct3 == 3'b000) begin
          ctrl.alub_src = 1'b1;
          ctrl.wr_reg_en = 1'b1;
        end
      end
      riscv_pkg::Lui: begin
        ctrl.alu_op = riscv_pkg::AluPassB;
        ctrl.alub_src = 1'b1;
        ctrl.wr_reg_en = 1'b1;
      end
      riscv_pkg::Load: begin
        // Word accesses only
        if (ctrl.funct3 == 3'b010) begin
          ctrl.alub_src = 1'b1;
          ctrl.wr_reg_src = riscv_pkg::WrReadData;
          ctrl.wr_reg_en = 1'b1;
          ctrl.mem_rd_en = 1'b1;
        end
      end
      riscv_pkg::Store: begin
        if (ctrl.funct3 == 3'b010) begin
          ctrl.alub_src = 1'b1;
          ctrl.mem_wr_en = 1'b1;
        end
      end
      riscv_pkg::Branch: begin
        if (ctrl.funct3 == 3'b000) begin
          ctrl.branch_type = riscv_pkg::BranchEq;
        end else if (ctrl.funct3 == 3'b001) begin
          ctrl.branch_type = riscv_pkg::BranchNe;
        end
      end
      riscv_pkg::Jal: begin
        ctrl.branch_type = riscv_pkg::BranchJal;
        ctrl.wr_reg_src = riscv_pkg::WrPcPlus4;
        ctrl.wr_reg_en = 1'b1;
      end
      default: begin
      end
    endcase
  end

endmodule

//--- hazard_unit.sv
`include "riscv_pipe_params.svh"

module hazard_unit (
  hazard_if.unit hz
);
  logic load_use;
  logic branch_on_ex;
  logic branch_on_mem_load;

  // Source register matches a live, nonzero destination
  function automatic logic hits(input logic [`REG_ADDR_W-1:0] rs,
                                input logic [`REG_ADDR_W-1:0] rd,
                                input logic we);
    return we && rd != '0 && rd == rs;
  endfunction

  // MEM has priority since it holds the younger result
  function automatic riscv_pkg::forwarding_t pick(input logic from_mem, input logic from_wb);
    if (from_mem) begin
      return riscv_pkg::ForwardFromMem;
    end
    if (from_wb) begin
      return riscv_pkg::ForwardFromWb;
    end
    return riscv_pkg::NoForwarding;
  endfunction

  // Load data is not ready in MEM for an ID consumer
  assign hz.forward_rs1_id = pick(hits(hz.rs1_id, hz.rd_mem, hz.reg_we_mem && !hz.mem_rd_en_mem),
                                  hits(hz.rs1_id, hz.rd_wb, hz.reg_we_wb));
  assign hz.forward_rs2_id = pick(hits(hz.rs2_id, hz.rd_mem, hz.reg_we_mem && !hz.mem_rd_en_mem),
                                  hits(hz.rs2_id, hz.rd_wb, hz.reg_we_wb));
  assign hz.forward_rs1_ex = pick(hits(hz.rs1_ex, hz.rd_mem, hz.reg_we_mem),
                                  hits(hz.rs1_ex, hz.rd_wb, hz.reg_we_wb));
  assign hz.forward_rs2_ex = pick(hits(hz.rs2_ex, hz.rd_mem, hz.reg_we_mem),
                                  hits(hz.rs2_ex, hz.rd_wb, hz.reg_we_wb));

  assign load_use = hz.mem_rd_en_ex &&
                    (hits(hz.rs1_id, hz.rd_ex, hz.reg_we_ex) ||
                     hits(hz.rs2_id, hz.rd_ex, hz.reg_we_ex));

  // Branches compare in ID, so any producer still in EX is too late
  assign branch_on_ex = hz.branch_id &&
                        (hits(hz.rs1_id, hz.rd_ex, hz.reg_we_ex) ||
                         hits(hz.rs2_id, hz.rd_ex, hz.reg_we_ex));

  assign branch_on_mem_load = hz.branch_id && hz.mem_rd_en_mem &&
                              (hits(hz.rs1_id, hz.rd_mem, hz.reg_we_mem) ||
                               hits(hz.rs2_id, hz.rd_mem, hz.reg_we_mem));

  assign hz.stall = load_use || branch_on_ex || branch_on_mem_load;
  assign hz.flush_id = hz.branch_taken && !hz.stall;

  // Stall cycles rely on an empty EX slot behind them
  stall_empties_ex: assert property (@(posedge hz.clock)
    hz.stall |=> !hz.reg_we_ex && !hz.mem_rd_en_ex);

endmodule

//--- dataflow.sv
`include "riscv_pipe_params.svh"

module dataflow (
  input  logic             clock,
  input  logic             reset,
  ctrl_if.datapath         ctrl,
  hazard_if.datapath       hz,
  output logic [`XLEN-1:0] imem_addr,
  input  logic [`XLEN-1:0] imem_data,
  output logic [`XLEN-1:0] dmem_addr,
  output logic [`XLEN-1:0] dmem_wr_data,
  output logic             dmem_rd_en,
  output logic             dmem_wr_en,
  input  logic [`XLEN-1:0] dmem_rd_data
);
  typedef struct packed {
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] inst;
  } if_id_t;

  typedef struct packed {
    logic [`XLEN-1:0]       pc_plus_4;
    logic [`XLEN-1:0]       rs1_data;
    logic [`XLEN-1:0]       rs2_data;
    logic [`XLEN-1:0]       imm;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rd;
    riscv_pkg::alu_op_t     alu_op;
    logic                   alub_src;
    riscv_pkg::wr_reg_t     wr_reg_src;
    logic                   wr_reg_en;
    logic                   mem_rd_en;
    logic                   mem_wr_en;
  } id_ex_t;

  typedef struct packed {
    logic [`XLEN-1:0]       pc_plus_4;
    logic [`XLEN-1:0]       alu_y;
    logic [`XLEN-1:0]       wr_data;
    logic [`REG_ADDR_W-1:0] rd;
    riscv_pkg::wr_reg_t     wr_reg_src;
    logic                   wr_reg_en;
    logic                   mem_rd_en;
    logic                   mem_wr_en;
  } ex_mem_t;

  typedef struct packed {
    logic [`XLEN-1:0]       pc_plus_4;
    logic [`XLEN-1:0]       alu_y;
    logic [`XLEN-1:0]       rd_data;
    logic [`REG_ADDR_W-1:0] rd;
    riscv_pkg::wr_reg_t     wr_reg_src;
    logic                   wr_reg_en;
  } mem_wb_t;

  logic [`XLEN-1:0] pc;
  if_id_t           if_id;
  id_ex_t           id_ex;
  ex_mem_t          ex_mem;
  mem_wb_t          mem_wb;
  logic [`REG_ADDR_W-1:0] rs1_id;
  logic [`REG_ADDR_W-1:0] rs2_id;
  logic [`XLEN-1:0] rs1_data;
  logic [`XLEN-1:0] rs2_data;
  logic [`XLEN-1:0] rs1_id_fwd;
  logic [`XLEN-1:0] rs2_id_fwd;
  logic [`XLEN-1:0] rs1_ex_fwd;
  logic [`XLEN-1:0] rs2_ex_fwd;
  logic [`XLEN-1:0] imm;
  logic [`XLEN-1:0] branch_target;
  logic [`XLEN-1:0] alu_y;
  logic [`XLEN-1:0] mem_value;
  logic [`XLEN-1:0] wb_value;
  logic [`XLEN-1:0] inst;

  function automatic logic [`XLEN-1:0] forward(input riscv_pkg::forwarding_t sel,
                                               input logic [`XLEN-1:0] reg_value,
                                               input logic [`XLEN-1:0] from_mem,
                                               input logic [`XLEN-1:0] from_wb);
    case (sel)
      riscv_pkg::ForwardFromMem: return from_mem;
      riscv_pkg::ForwardFromWb: return from_wb;
      default: return reg_value;
    endcase
  endfunction

  // IF, a zero word in IF/ID decodes as a bubble
  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= `RESET_PC;
      if_id <= '0;
    end else if (!hz.stall) begin
      pc <= hz.flush_id ? branch_target : pc + `XLEN'd4;
      if_id <= hz.flush_id ? '0 : if_id_t'{pc: pc, inst: imem_data};
    end
  end

  // ID
  assign inst = if_id.inst;
  assign ctrl.opcode = riscv_pkg::opcode_t'(inst[6:0]);
  assign ctrl.funct3 = inst[14:12];
  assign ctrl.funct7 = inst[31:25];
  // Unused source fields must not raise false hazards
  assign rs1_id = (ctrl.opcode inside {riscv_pkg::Lui, riscv_pkg::Jal}) ? '0 : inst[19:15];
  assign rs2_id = (ctrl.opcode inside {riscv_pkg::OpReg, riscv_pkg::Store, riscv_pkg::Branch})
                  ? inst[24:20] : '0;

  always_comb begin
    case (ctrl.opcode)
      riscv_pkg::Store: imm = {{(`XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
      riscv_pkg::Lui: imm = {inst[31:12], 12'b0};
      riscv_pkg::Branch: begin
        imm = {{(`XLEN-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      end
      riscv_pkg::Jal: begin
        imm = {{(`XLEN-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      default: imm = {{(`XLEN-12){inst[31]}}, inst[31:20]};
    endcase
  end

  register_file register_file_inst (
    .clock(clock),
    .reset(reset),
    .write_enable(mem_wb.wr_reg_en),
    .write_address(mem_wb.rd),
    .write_data(wb_value),
    .read_address1(rs1_id),
    .read_address2(rs2_id),
    .read_data1(rs1_data),
    .read_data2(rs2_data)
  );

  assign rs1_id_fwd = forward(hz.forward_rs1_id, rs1_data, mem_value, wb_value);
  assign rs2_id_fwd = forward(hz.forward_rs2_id, rs2_data, mem_value, wb_value);
  assign branch_target = if_id.pc + imm;
  assign hz.branch_id = ctrl.branch_type inside {riscv_pkg::BranchEq, riscv_pkg::BranchNe};
  assign hz.branch_taken = ctrl.branch_type == riscv_pkg::BranchJal ||
                           (ctrl.branch_type == riscv_pkg::BranchEq && rs1_id_fwd == rs2_id_fwd) ||
                           (ctrl.branch_type == riscv_pkg::BranchNe && rs1_id_fwd != rs2_id_fwd);

  always_ff @(posedge clock) begin
    if (reset || hz.stall) begin
      id_ex <= '0;
    end else begin
      id_ex <= '{pc_plus_4: if_id.pc + `XLEN'd4, rs1_data: rs1_id_fwd, rs2_data: rs2_id_fwd,
                 imm: imm, rs1: rs1_id, rs2: rs2_id, rd: inst[11:7], alu_op: ctrl.alu_op,
                 alub_src: ctrl.alub_src, wr_reg_src: ctrl.wr_reg_src,
                 wr_reg_en: ctrl.wr_reg_en, mem_rd_en: ctrl.mem_rd_en,
                 mem_wr_en: ctrl.mem_wr_en};
    end
  end

  // EX
  assign rs1_ex_fwd = forward(hz.forward_rs1_ex, id_ex.rs1_data, mem_value, wb_value);
  assign rs2_ex_fwd = forward(hz.forward_rs2_ex, id_ex.rs2_data, mem_value, wb_value);

  alu alu_inst (
    .a(rs1_ex_fwd),
    .b(id_ex.alub_src ? id_ex.imm : rs2_ex_fwd),
    .alu_op(id_ex.alu_op),
    .y(alu_y)
  );

  always_ff @(posedge clock) begin
    if (reset) begin
      ex_mem <= '0;
    end else begin
      ex_mem <= '{pc_plus_4: id_ex.pc_plus_4, alu_y: alu_y, wr_data: rs2_ex_fwd,
                  rd: id_ex.rd, wr_reg_src: id_ex.wr_reg_src, wr_reg_en: id_ex.wr_reg_en,
                  mem_rd_en: id_ex.mem_rd_en, mem_wr_en: id_ex.mem_wr_en};
    end
  end

  // MEM
  assign mem_value = (ex_mem.wr_reg_src == riscv_pkg::WrPcPlus4) ? ex_mem.pc_plus_4
                                                                : ex_mem.alu_y;

  always_ff @(posedge clock) begin
    if (reset) begin
      mem_wb <= '0;
    end else begin
      mem_wb <= '{pc_plus_4: ex_mem.pc_plus_4, alu_y: ex_mem.alu_y, rd_data: dmem_rd_data,
                  rd: ex_mem.rd, wr_reg_src: ex_mem.wr_reg_src, wr_reg_en: ex_mem.wr_reg_en};
    end
  end

  // WB
  always_comb begin
    case (mem_wb.wr_reg_src)
      riscv_pkg::WrReadData: wb_value = mem_wb.rd_data;
      riscv_pkg::WrPcPlus4: wb_value = mem_wb.pc_plus_4;
      default: wb_value = mem_wb.alu_y;
    endcase
  end

  assign imem_addr = pc;
  assign dmem_addr = ex_mem.alu_y;
  assign dmem_wr_data = ex_mem.wr_data;
  assign dmem_rd_en = ex_mem.mem_rd_en;
  assign dmem_wr_en = ex_mem.mem_wr_en;

  assign hz.rs1_id = rs1_id;
  assign hz.rs2_id = rs2_id;
  assign hz.rs1_ex = id_ex.rs1;
  assign hz.rs2_ex = id_ex.rs2;
  assign hz.rd_ex = id_ex.rd;
  assign hz.rd_mem = ex_mem.rd;
  assign hz.rd_wb = mem_wb.rd;
  assign hz.reg_we_ex = id_ex.wr_reg_en;
  assign hz.reg_we_mem = ex_mem.wr_reg_en;
  assign hz.reg_we_wb = mem_wb.wr_reg_en;
  assign hz.mem_rd_en_ex = id_ex.mem_rd_en;
  assign hz.mem_rd_en_mem = ex_mem.mem_rd_en;

  dmem_one_access: assert property (@(posedge clock) disable iff (reset)
    !(dmem_rd_en && dmem_wr_en));

  // A branch redirects only once no operand is still being produced in EX
  branch_waits_for_ex: assert property (@(posedge clock) disable iff (reset)
    hz.flush_id && hz.branch_id |-> !(hz.reg_we_ex && hz.rd_ex != '0 &&
                                      (hz.rd_ex == rs1_id || hz.rd_ex == rs2_id)));

endmodule

//--- riscv_pipe.sv
`include "riscv_pipe_params.svh"

module riscv_pipe (
  input  logic             clock,
  input  logic             reset,
  output logic [`XLEN-1:0] imem_addr,
  input  logic [`XLEN-1:0] imem_data,
  output logic [`XLEN-1:0] dmem_addr,
  output logic [`XLEN-1:0] dmem_wr_data,
  output logic             dmem_rd_en,
  output logic             dmem_wr_en,
  input  logic [`XLEN-1:0] dmem_rd_data
);

  ctrl_if ctrl_bus ();

  hazard_if hazard_bus (
    .clock(clock)
  );

  control_unit control_unit_inst (
    .ctrl(ctrl_bus.decoder)
  );

  hazard_unit hazard_unit_inst (
    .hz(hazard_bus.unit)
  );

  dataflow dataflow_inst (
    .clock(clock),
    .reset(reset),
    .ctrl(ctrl_bus.datapath),
    .hz(hazard_bus.datapath),
    .imem_addr(imem_addr),
    .imem_data(imem_data),
    .dmem_addr(dmem_addr),
    .dmem_wr_data(dmem_wr_data),
    .dmem_rd_en(dmem_rd_en),
    .dmem_wr_en(dmem_wr_en),
    .dmem_rd_data(dmem_rd_data)
  );

endmodule

//--- tb_clock.sv
module tb_clock #(
  parameter int period = 10,
  parameter int reset_cycles = 2
) (
  output logic clock,
  output logic reset
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clock = 1'b0;
    forever #(period / 2) clock = ~clock;
  end

  initial begin
    reset <= 1'b1;
    repeat (reset_cycles) @(posedge clock);
    reset <= 1'b0;
  end

endmodule

//--- riscv_pipe_tb.sv
module riscv_pipe_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int clock_period = 10;
  localparam int reset_cycles = 2;
  localparam int cycles_per_test = 200;
  // Five directed programs and twenty random pairs
  localparam int num_runs = 25;
  localparam logic [31:0] marker_addr = 32'h0000_0ffc;
  localparam logic [31:0] skip_addr = 32'h0000_03f0;
  localparam logic [2:0] beq_f3 = 3'b000;
  localparam logic [2:0] bne_f3 = 3'b001;

  typedef enum {alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt} alu_kind_t;

  logic clock;
  logic startup_reset;
  logic restart;
  logic reset;
  logic [31:0] imem_addr;
  logic [31:0] imem_data;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_wr_data;
  logic dmem_rd_en;
  logic dmem_wr_en;
  logic [31:0] dmem_rd_data;
  logic [31:0] imem [256];
  logic [31:0] dmem [1024];
  logic [31:0] log_addr [$];
  logic [31:0] log_data [$];
  logic marker_seen;
  logic [31:0] prog [$];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  int next_slot;
  int load_count;
  int exp_loads;
  int checks;
  int errors;

  tb_clock #(.period(clock_period), .reset_cycles(reset_cycles)) tb_clock_inst (
    .clock(clock),
    .reset(startup_reset)
  );

  assign reset = startup_reset | restart;

  riscv_pipe riscv_pipe_inst (
    .clock(clock),
    .reset(reset),
    .imem_addr(imem_addr),
    .imem_data(imem_data),
    .dmem_addr(dmem_addr),
    .dmem_wr_data(dmem_wr_data),
    .dmem_rd_en(dmem_rd_en),
    .dmem_wr_en(dmem_wr_en),
    .dmem_rd_data(dmem_rd_data)
  );

  assign imem_data = imem[imem_addr[9:2]];
  assign dmem_rd_data = reset ? 32'h0 : dmem[dmem_addr[11:2]];

  function automatic logic [31:0] fill_value(input int addr);
    return 32'h5a5a_0000 ^ addr;
  endfunction

  // Data memory, refilled on every reset, logs each store in order
  always @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 1024; i++) begin
        dmem[i] <= fill_value(i * 4);
      end
      log_addr.delete();
      log_data.delete();
      marker_seen <= 1'b0;
      load_count <= 0;
    end else begin
      // Each load reads in exactly one MEM cycle
      if (dmem_rd_en) begin
        load_count <= load_count + 1;
      end
      if (dmem_wr_en) begin
        dmem[dmem_addr[11:2]] <= dmem_wr_data;
        log_addr.push_back(dmem_addr);
        log_data.push_back(dmem_wr_data);
        if (dmem_addr == marker_addr) begin
          marker_seen <= 1'b1;
        end
      end
    end
  end

  task automatic emit(input logic [31:0] word);
    prog.push_back(word);
  endtask

  task automatic addi(input int rd, input int rs1, input int imm);
    emit({imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011});
  endtask

  task automatic lui(input int rd, input logic [19:0] imm);
    emit({imm, rd[4:0], 7'b0110111});
  endtask

  task automatic lw(input int rd, input int rs1, input int off);
    emit({off[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011});
    exp_loads++;
  endtask

  task automatic sw(input int rs2, input int rs1, input int off);
    emit({off[11:5], rs2[4:0], rs1[4:0], 3'b010, off[4:0], 7'b0100011});
  endtask

  task automatic branch(input logic [2:0] f3, input int rs1, input int rs2, input int off);
    emit({off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], 7'b1100011});
  endtask

  task automatic jal(input int rd, input int off);
    emit({off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111});
  endtask

  task automatic reg_op(input alu_kind_t kind, input int rd, input int rs1, input int rs2);
    logic [2:0] f3;
    case (kind)
      alu_add, alu_sub: f3 = 3'b000;
      alu_and: f3 = 3'b111;
      alu_or: f3 = 3'b110;
      alu_xor: f3 = 3'b100;
      default: f3 = 3'b010;
    endcase
    emit({(kind == alu_sub) ? 7'b0100000 : 7'b0000000, rs2[4:0], rs1[4:0], f3, rd[4:0],
          7'b0110011});
  endtask

  function automatic logic [31:0] expected_alu(input alu_kind_t kind, input logic [31:0] a,
                                               input logic [31:0] b);
    case (kind)
      alu_add: return a + b;
      alu_sub: return a - b;
      alu_and: return a & b;
      alu_or: return a | b;
      alu_xor: return a ^ b;
      default: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    endcase
  endfunction

  // Upper part rounds up when the low 12 bits sign-extend negative
  task automatic load_const(input int rd, input logic [31:0] value);
    logic [31:0] upper;
    upper = (value + 32'h800) >> 12;
    lui(rd, upper[19:0]);
    addi(rd, rd, int'(value));
  endtask

  function automatic logic [31:0] next_pc();
    return prog.size() * 4;
  endfunction

  task automatic start_program();
    prog.delete();
    exp_addr.delete();
    exp_data.delete();
    next_slot = 0;
    exp_loads = 0;
  endtask

  task automatic store_at(input int rs, input logic [31:0] addr, input logic [31:0] value);
    sw(rs, 0, addr);
    exp_addr.push_back(addr);
    exp_data.push_back(value);
  endtask

  task automatic store_result(input int rs, input logic [31:0] value);
    store_at(rs, 32'h100 + next_slot * 4, value);
    next_slot++;
  endtask

  // Sits right behind a taken branch or jump, so it must never reach memory
  task automatic skip_store(input int rs);
    sw(rs, 0, skip_addr);
  endtask

  task automatic end_program();
    lui(31, 20'h00001);
    sw(0, 31, -4);
  endtask

  // Unused words are ADDI to x0 with the word index as immediate
  task automatic load_imem();
    for (int i = 0; i < 256; i++) begin
      if (i < prog.size()) begin
        imem[i] = prog[i];
      end else begin
        imem[i] = {i[11:0], 5'd0, 3'b000, 5'd0, 7'b0010011};
      end
    end
  endtask

  task automatic run_program(input string name);
    int cycles;
    int logged;
    @(posedge clock);
    restart <= 1'b1;
    // New program goes in while the core is held in reset
    @(posedge clock);
    load_imem();
    repeat (reset_cycles - 1) @(posedge clock);
    restart <= 1'b0;
    cycles = reset_cycles + 1;
    while (!marker_seen && cycles < cycles_per_test) begin
      @(negedge clock);
      cycles++;
    end
    if (!marker_seen) begin
      $display("Program %s never reached its end marker store within %0d cycles",
               name, cycles_per_test);
      errors++;
    end else begin
      logged = log_addr.size() - 1;
      checks++;
      if (logged != exp_addr.size()) begin
        $display("Error at %0t: %s made %0d stores, expected %0d",
                 $time, name, logged, exp_addr.size());
        errors++;
      end
      checks++;
      if (load_count != exp_loads) begin
        $display("Error at %0t: %s raised the data read enable %0d times, expected %0d",
                 $time, name, load_count, exp_loads);
        errors++;
      end
      for (int i = 0; i < logged && i < exp_addr.size(); i++) begin
        checks++;
        if (log_addr[i] != exp_addr[i] || log_data[i] != exp_data[i]) begin
          $display("Error at %0t: %s store %0d wrote %h to %h, expected %h to %h",
                   $time, name, i, log_data[i], log_addr[i], exp_data[i], exp_addr[i]);
          errors++;
        end
      end
    end
  endtask

  task automatic alu_chain_test();
    logic [31:0] r [1:9];
    start_program();
    r[1] = 32'd25;
    r[2] = r[1] - 32'd7;
    r[3] = r[1] + r[2];
    r[4] = r[3] - r[1];
    r[5] = r[4] & r[3];
    r[6] = r[5] | r[4];
    r[7] = r[6] ^ r[3];
    r[8] = ($signed(r[4]) < $signed(r[7])) ? 32'd1 : 32'd0;
    r[9] = 32'd0 - r[7];
    addi(1, 0, 25);
    addi(2, 1, -7);
    reg_op(alu_add, 3, 1, 2);
    reg_op(alu_sub, 4, 3, 1);
    reg_op(alu_and, 5, 4, 3);
    reg_op(alu_or, 6, 5, 4);
    reg_op(alu_xor, 7, 6, 3);
    reg_op(alu_slt, 8, 4, 7);
    reg_op(alu_sub, 9, 0, 7);
    // Signed compare in both directions against a negative value
    reg_op(alu_slt, 10, 9, 8);
    reg_op(alu_slt, 11, 8, 9);
    for (int i = 1; i <= 9; i++) begin
      store_result(i, r[i]);
    end
    store_result(10, ($signed(r[9]) < $signed(r[8])) ? 32'd1 : 32'd0);
    store_result(11, ($signed(r[8]) < $signed(r[9])) ? 32'd1 : 32'd0);
    end_program();
    run_program("alu_chain");
  endtask

  task automatic lui_test();
    start_program();
    load_const(1, 32'h1234_5678);
    load_const(2, 32'hdead_beef);
    load_const(3, 32'hffff_f800);
    lui(4, 20'h80000);
    addi(0, 0, 99);
    reg_op(alu_add, 0, 1, 2);
    lui(0, 20'h12345);
    reg_op(alu_add, 5, 0, 1);
    store_result(1, 32'h1234_5678);
    store_result(2, 32'hdead_beef);
    store_result(3, 32'hffff_f800);
    store_result(4, 32'h8000_0000);
    store_result(0, 32'h0);
    store_result(5, 32'h1234_5678);
    end_program();
    run_program("lui_constants");
  endtask

  task automatic load_use_test();
    logic [31:0] value;
    start_program();
    value = 32'h0bad_f00d;
    addi(1, 0, 100);
    load_const(2, value);
    store_at(2, 32'h200, value);
    lw(3, 0, 32'h200);
    reg_op(alu_add, 4, 3, 1);
    store_result(4, value + 32'd100);
    lw(5, 0, 32'h300);
    addi(6, 5, 1);
    store_result(6, fill_value(32'h300) + 32'd1);
    lw(7, 0, 32'h200);
    store_at(7, 32'h204, value);
    lw(8, 0, 32'h204);
    store_result(8, value);
    end_program();
    run_program("load_use");
  endtask

  task automatic branch_test();
    start_program();
    addi(1, 0, 5);
    addi(2, 0, 5);
    branch(beq_f3, 1, 2, 8);
    skip_store(1);
    store_result(2, 32'd5);
    addi(3, 0, 7);
    branch(bne_f3, 1, 3, 8);
    skip_store(3);
    branch(beq_f3, 1, 3, 8);
    store_result(3, 32'd7);
    branch(bne_f3, 1, 2, 8);
    store_result(1, 32'd5);
    store_at(2, 32'h240, 32'd5);
    // Load still in EX when the branch decodes
    lw(4, 0, 32'h240);
    branch(bne_f3, 4, 2, 8);
    store_result(4, 32'd5);
    // Load already in MEM
    lw(5, 0, 32'h240);
    addi(6, 0, 9);
    branch(beq_f3, 5, 2, 8);
    skip_store(5);
    store_result(6, 32'd9);
    // Backward loop, three passes
    addi(7, 0, 3);
    addi(8, 0, 0);
    addi(8, 8, 1);
    addi(7, 7, -1);
    branch(bne_f3, 7, 0, -8);
    store_result(8, 32'd3);
    store_result(7, 32'd0);
    end_program();
    run_program("branches");
  endtask

  task automatic jal_test();
    logic [31:0] link1;
    logic [31:0] link2;
    start_program();
    addi(1, 0, 1);
    link1 = next_pc() + 32'd4;
    jal(5, 8);
    skip_store(1);
    store_result(5, link1);
    link2 = next_pc() + 32'd4;
    jal(6, 12);
    skip_store(1);
    skip_store(5);
    store_result(6, link2);
    jal(0, 8);
    skip_store(6);
    store_result(0, 32'd0);
    store_result(1, 32'd1);
    end_program();
    run_program("jal");
  endtask

  task automatic random_alu_test();
    logic [31:0] a;
    logic [31:0] b;
    int imm;
    for (int pair = 0; pair < 20; pair++) begin
      a = $urandom();
      b = (pair % 5 == 4) ? a : $urandom();
      imm = int'($urandom_range(4095)) - 2048;
      start_program();
      load_const(1, a);
      load_const(2, b);
      for (int k = 0; k < 6; k++) begin
        reg_op(alu_kind_t'(k), 3, 1, 2);
        store_result(3, expected_alu(alu_kind_t'(k), a, b));
      end
      reg_op(alu_slt, 4, 2, 1);
      store_result(4, expected_alu(alu_slt, b, a));
      addi(5, 1, imm);
      store_result(5, a + 32'(imm));
      end_program();
      run_program($sformatf("random_pair_%0d", pair));
    end
  endtask

  initial begin
    void'($urandom(32'hac1d_c032));
    checks = 0;
    errors = 0;
    restart <= 1'b0;
    prog.delete();
    load_imem();
    wait (startup_reset == 1'b0);
    alu_chain_test();
    lui_test();
    load_use_test();
    branch_test();
    jal_test();
    random_alu_test();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // One spare cycle per run covers the edge alignment at its start
  initial begin
    #((num_runs * (cycles_per_test + 1) + reset_cycles) * clock_period);
    $display("Watchdog expired with the tests still running at %0t", $time);
    $display("Something failed");
    $finish;
  end

endmodule

//--- riscv_pipe.f
+incdir+.
riscv_pkg.sv
pipe_ifs.sv
register_file.sv
alu.sv
control_unit.sv
hazard_unit.sv
dataflow.sv
riscv_pipe.sv
tb_clock.sv
riscv_pipe_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -eo pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --timescale 1ns/1ps \
  --top-module riscv_pipe_tb \
  -f riscv_pipe.f

./obj_dir/Vriscv_pipe_tb | tee sim.log

if grep -q "Everything OK" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation did not pass, see sim.log"
  exit 1
fi
